// File: rename.f
+incdir+src
src/rename_pkg.sv
src/rob_tracker.sv
src/reg_source_map.sv
src/rename_top.sv
verif/rename_asserts.sv
verif/rename_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the rename testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rename_tb -f rename.f -o rename_sim || exit 1
sim_out="$(./obj_dir/rename_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Simulation passed" && exit 0 || exit 1

// File: src/reg_source_map.sv
// Lookups see the map before this edge's update; only slot 1 bypasses from slot 0 of the same pair
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module reg_source_map (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                alloc0,
	input  wire logic                alloc1,
	input  rename_pkg::rob_tag_t     tag0,
	input  rename_pkg::rob_tag_t     tag1,
	input  rename_pkg::reg_idx_t     rt0,
	input  rename_pkg::reg_idx_t     rt1,
	input  rename_pkg::reg_idx_t     rs0,
	input  rename_pkg::reg_idx_t     rs1,
	input  wire logic                retire,
	input  rename_pkg::rob_tag_t     retire_tag,
	input  rename_pkg::reg_idx_t     retire_rt,
	input  wire logic                flush,
	input  rename_pkg::reg_mask_t    latest_writer [`ROB_ENTRIES],
	output rename_pkg::src_t         rs0_src,
	output rename_pkg::src_t         rs1_src
);

	import rename_pkg::*;

	// ======================================================================
	// Source table
	// ======================================================================

	// One entry per register, a tag while a writer is in flight, else SRC_NONE
	src_t src_q [`NREGS];
	src_t src_n [`NREGS];

	// Tags widened to source codes
	src_t tag0_src;
	src_t tag1_src;
	src_t retire_src;

	assign tag0_src   = {1'b0, tag0};
	assign tag1_src   = {1'b0, tag1};
	assign retire_src = {1'b0, retire_tag};

	// ======================================================================
	// Operand lookup
	// ======================================================================

	// Register 0 always reads as none since its table entry is pinned
	assign rs0_src = src_q[rs0];

	// Slot 1 depends on slot 0 when it reads what slot 0 writes in the same pair
	always_comb begin
		if (alloc0 && (rt0 != '0) && (rs1 == rt0))
			rs1_src = tag0_src;
		else
			rs1_src = src_q[rs1];
	end

	// ======================================================================
	// Next state
	// ======================================================================

	always_comb begin
		for (int r = 0; r < `NREGS; r++)
			src_n[r] = src_q[r];

		if (flush) begin
			// Rebuild every register from the surviving writers
			// At most one entry owns a given register bit, so the loop order is irrelevant
			for (int r = 0; r < `NREGS; r++) begin
				src_n[r] = SRC_NONE;
				for (int e = 0; e < `ROB_ENTRIES; e++) begin
					if (latest_writer[e][r])
						src_n[r] = src_t'(e);
				end
			end
		end else begin
			// Commit clear comes first so a writer decoded this edge survives it
			// The tag check keeps a younger writer that already replaced the retiring one
			if (retire && (src_q[retire_rt] == retire_src))
				src_n[retire_rt] = SRC_NONE;
			// Slot 1 is younger, so it wins when both slots hit the same register
			if (alloc0 && (rt0 != '0))
				src_n[rt0] = tag0_src;
			if (alloc1 && (rt1 != '0))
				src_n[rt1] = tag1_src;
		end

		// Register 0 is hardwired and never renamed
		src_n[0] = SRC_NONE;
	end

	// ======================================================================
	// State register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `NREGS; r++)
				src_q[r] <= SRC_NONE;
		end else begin
			for (int r = 0; r < `NREGS; r++)
				src_q[r] <= src_n[r];
		end
	end

endmodule

`default_nettype wire

// File: src/rename_macros.svh
// Sizes are fixed for an 8-entry ROB and 32 registers; TAG_W must equal log2 of ROB_ENTRIES
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// ==========================================================================
// Rename front end sizing
// ==========================================================================

// Number of architectural registers, register 0 is hardwired and never mapped
`define NREGS 32

// Reorder-buffer depth, one tag per entry
`define ROB_ENTRIES 8

// Width of a reorder-buffer tag
// A source value is one bit wider so that the "none" code sits just above the tags
`define TAG_W 3

`endif

// File: src/rename_pkg.sv
// Types assume the sizes from rename_macros.svh; the none code is the first value past the last tag
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

	// Architectural register number
	typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

	// Reorder-buffer entry number
	typedef logic [`TAG_W-1:0] rob_tag_t;

	// Source of a register value
	// Codes below ROB_ENTRIES are a tag, ROB_ENTRIES itself means the register file
	typedef logic [`TAG_W:0] src_t;

	// One bit per architectural register
	typedef logic [`NREGS-1:0] reg_mask_t;

	// One bit per reorder-buffer entry
	typedef logic [`ROB_ENTRIES-1:0] rob_mask_t;

	// The register file holds the committed value
	localparam src_t SRC_NONE = src_t'(`ROB_ENTRIES);

endpackage

`default_nettype wire

// File: src/rename_top.sv
// Caller must hold a decode pair while ready is low and give dec1 only with dec0; outputs are unbuffered
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_top (
	input  wire logic                clk,
	input  wire logic                rst,
	// Decode pair
	input  wire logic                dec0_valid,
	input  rename_pkg::reg_idx_t     dec0_rt,
	input  rename_pkg::reg_idx_t     dec0_rs,
	input  wire logic                dec1_valid,
	input  rename_pkg::reg_idx_t     dec1_rt,
	input  rename_pkg::reg_idx_t     dec1_rs,
	// Execution results and branch outcome, single-cycle pulses
	input  wire logic                comp_valid,
	input  rename_pkg::rob_tag_t     comp_tag,
	input  wire logic                miss_valid,
	input  rename_pkg::rob_tag_t     miss_tag,
	// Rename results
	output logic                     ready,
	output rename_pkg::rob_tag_t     dec0_tag,
	output rename_pkg::rob_tag_t     dec1_tag,
	output rename_pkg::src_t         dec0_rs_src,
	output rename_pkg::src_t         dec1_rs_src,
	// Registered commit report
	output logic                     commit_valid,
	output rename_pkg::reg_idx_t     commit_rt,
	output rename_pkg::rob_tag_t     commit_tag
);

	import rename_pkg::*;

	// Accepted decode, retirement and flush events from the tracker
	logic      alloc0;
	logic      alloc1;
	logic      retire;
	rob_tag_t  retire_tag;
	reg_idx_t  retire_rt;
	logic      flush;
	reg_mask_t latest_writer [`ROB_ENTRIES];

	rob_tracker u_rob (
		.clk           (clk),
		.rst           (rst),
		.alloc0_req    (dec0_valid),
		.alloc1_req    (dec1_valid),
		.rt0           (dec0_rt),
		.rt1           (dec1_rt),
		.comp_valid    (comp_valid),
		.comp_tag      (comp_tag),
		.miss_valid    (miss_valid),
		.miss_tag      (miss_tag),
		.ready         (ready),
		.alloc0        (alloc0),
		.alloc1        (alloc1),
		.tag0          (dec0_tag),
		.tag1          (dec1_tag),
		.retire        (retire),
		.retire_tag    (retire_tag),
		.retire_rt     (retire_rt),
		.flush         (flush),
		.latest_writer (latest_writer),
		.commit_valid  (commit_valid),
		.commit_tag    (commit_tag),
		.commit_rt     (commit_rt)
	);

	reg_source_map u_map (
		.clk           (clk),
		.rst           (rst),
		.alloc0        (alloc0),
		.alloc1        (alloc1),
		.tag0          (dec0_tag),
		.tag1          (dec1_tag),
		.rt0           (dec0_rt),
		.rt1           (dec1_rt),
		.rs0           (dec0_rs),
		.rs1           (dec1_rs),
		.retire        (retire),
		.retire_tag    (retire_tag),
		.retire_rt     (retire_rt),
		.flush         (flush),
		.latest_writer (latest_writer),
		.rs0_src       (dec0_rs_src),
		.rs1_src       (dec1_rs_src)
	);

endmodule

`default_nettype wire

// File: src/rob_tracker.sv
// Assumes miss_tag names a live entry and dec1 is only offered with dec0; retires one entry a cycle
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rob_tracker (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                alloc0_req,
	input  wire logic                alloc1_req,
	input  rename_pkg::reg_idx_t     rt0,
	input  rename_pkg::reg_idx_t     rt1,
	input  wire logic                comp_valid,
	input  rename_pkg::rob_tag_t     comp_tag,
	input  wire logic                miss_valid,
	input  rename_pkg::rob_tag_t     miss_tag,
	output logic                     ready,
	output logic                     alloc0,
	output logic                     alloc1,
	output rename_pkg::rob_tag_t     tag0,
	output rename_pkg::rob_tag_t     tag1,
	output logic                     retire,
	output rename_pkg::rob_tag_t     retire_tag,
	output rename_pkg::reg_idx_t     retire_rt,
	output logic                     flush,
	output rename_pkg::reg_mask_t    latest_writer [`ROB_ENTRIES],
	output logic                     commit_valid,
	output rename_pkg::rob_tag_t     commit_tag,
	output rename_pkg::reg_idx_t     commit_rt
);

	import rename_pkg::*;

	// ======================================================================
	// Entry state
	// ======================================================================

	// Live and done flags per entry
	// Live entries run contiguously from the head
	rob_mask_t live;
	rob_mask_t done;
	// Target register of each entry
	// Register 0 marks an instruction that writes nothing
	reg_idx_t  rt_q [`ROB_ENTRIES];
	rob_tag_t  head;
	rob_tag_t  tail;
	// Occupancy needs one more bit than a tag since a full ROB has head == tail
	logic [`TAG_W:0] count;

	// Distance of the mispredicted entry from the oldest one
	rob_tag_t  miss_off;
	// Entries younger than miss_tag, and the ones that survive this edge
	rob_mask_t squash;
	rob_mask_t keep;

	// Two free entries are needed for a full decode pair, and a miss stalls decode
	assign ready  = (count <= (`ROB_ENTRIES - 2)) && !miss_valid;
	assign alloc0 = alloc0_req && ready;
	assign alloc1 = alloc1_req && alloc0;

	assign tag0 = tail;
	assign tag1 = tail + 1'b1;

	// A miss on the same edge holds the head back so the squash sees a fixed range
	assign retire     = live[head] && done[head] && !miss_valid;
	assign retire_tag = head;
	assign retire_rt  = rt_q[head];

	assign flush    = miss_valid;
	assign miss_off = miss_tag - head;

	// Squashed entries sit past the mispredicted one but still inside the live range
	always_comb begin : squash_scan
		rob_tag_t idx;
		squash = '0;
		for (int k = 0; k < `ROB_ENTRIES; k++) begin
			idx = head + k[`TAG_W-1:0];
			if (miss_valid && (k > int'(miss_off)) && (k < int'(count)))
				squash[idx] = 1'b1;
		end
	end

	assign keep = live & ~squash;

	// ======================================================================
	// Youngest live writer per register
	// ======================================================================

	// Walk from oldest to youngest so a later writer takes the bit from an older one
	always_comb begin : writer_scan
		rob_tag_t idx;
		for (int e = 0; e < `ROB_ENTRIES; e++)
			latest_writer[e] = '0;
		for (int k = 0; k < `ROB_ENTRIES; k++) begin
			idx = head + k[`TAG_W-1:0];
			if (keep[idx] && (rt_q[idx] != '0)) begin
				for (int e = 0; e < `ROB_ENTRIES; e++)
					latest_writer[e][rt_q[idx]] = 1'b0;
				latest_writer[idx][rt_q[idx]] = 1'b1;
			end
		end
	end

	// ======================================================================
	// Control state
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			live         <= '0;
			done         <= '0;
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
			// Late completions for entries that are gone are dropped
			if (comp_valid && live[comp_tag])
				done[comp_tag] <= 1'b1;
			if (retire) begin
				live[head] <= 1'b0;
				done[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			if (flush) begin
				// Squashed entries keep stale done bits until a new allocation clears them
				live  <= keep;
				tail  <= miss_tag + 1'b1;
				count <= {1'b0, miss_off} + {{`TAG_W{1'b0}}, 1'b1};
			end else begin
				count <= count + {{`TAG_W{1'b0}}, alloc0} + {{`TAG_W{1'b0}}, alloc1}
					- {{`TAG_W{1'b0}}, retire};
				if (alloc1)
					tail <= tail + 2'd2;
				else if (alloc0)
					tail <= tail + 1'b1;
			end
			// Fresh entries start not done
			if (alloc0) begin
				live[tag0] <= 1'b1;
				done[tag0] <= 1'b0;
			end
			if (alloc1) begin
				live[tag1] <= 1'b1;
				done[tag1] <= 1'b0;
			end
		end
	end

	// Payload is only meaningful while the entry is live
	always_ff @(posedge clk) begin
		if (alloc0)
			rt_q[tag0] <= rt0;
		if (alloc1)
			rt_q[tag1] <= rt1;
		commit_tag <= head;
		commit_rt  <= rt_q[head];
	end

endmodule

`default_nettype wire

// File: verif/rename_asserts.sv
// Bound into rob_tracker and reads its internal count; every property is disabled during reset
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_asserts (
	input wire logic            clk,
	input wire logic            rst,
	input wire logic [`TAG_W:0] count,
	input wire logic            ready,
	input wire logic            alloc0,
	input wire logic            alloc1,
	input wire logic            retire,
	input wire logic            flush
);

	// ======================================================================
	// Tracker invariants
	// ======================================================================

	// Occupancy can never pass the ROB depth
	count_in_range: assert property (@(posedge clk) disable iff (rst)
		count <= `ROB_ENTRIES)
		else $error("ROB occupancy is above the ROB depth");

	// The second slot only allocates together with the first
	pair_order: assert property (@(posedge clk) disable iff (rst)
		alloc1 |-> alloc0)
		else $error("Slot 1 allocated without slot 0");

	// A misprediction edge freezes the head
	no_retire_on_flush: assert property (@(posedge clk) disable iff (rst)
		flush |-> !retire)
		else $error("Retirement on a flush edge");

	// Fewer than two free entries must stall decode
	stall_when_full: assert property (@(posedge clk) disable iff (rst)
		(count > (`ROB_ENTRIES - 2)) |-> !ready)
		else $error("Ready is high with fewer than two free entries");

endmodule

`default_nettype wire

// File: verif/rename_tb.sv
// Vector file path is relative to the project root; completions only target entries due to retire
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_tb;

	import rename_pkg::*;

	localparam int VEC_DEPTH   = 64;
	localparam int DRAIN_LIMIT = 200;

	logic      clk;
	logic      rst;
	logic      dec0_valid;
	reg_idx_t  dec0_rt;
	reg_idx_t  dec0_rs;
	logic      dec1_valid;
	reg_idx_t  dec1_rt;
	reg_idx_t  dec1_rs;
	logic      comp_valid;
	rob_tag_t  comp_tag;
	logic      miss_valid;
	rob_tag_t  miss_tag;
	logic      ready;
	rob_tag_t  dec0_tag;
	rob_tag_t  dec1_tag;
	src_t      dec0_rs_src;
	src_t      dec1_rs_src;
	logic      commit_valid;
	reg_idx_t  commit_rt;
	rob_tag_t  commit_tag;

	// One vector word per line with the layout given at the top of the vector file
	logic [59:0] vec_mem [VEC_DEPTH];

	// Reference ROB holding entries in allocation order from the oldest
	rob_tag_t  order_q [$];
	reg_idx_t  ent_rt [`ROB_ENTRIES];
	logic      ent_done [`ROB_ENTRIES];
	rob_tag_t  next_tag;
	// Commit pulse expected in the cycle after a retiring edge
	logic      exp_commit;
	rob_tag_t  exp_ctag;
	reg_idx_t  exp_crt;

	logic [31:0] rnd;
	logic        timed_out;
	int          check_count;
	int          error_count;
	int          timeout_count;

	rename_top UUT (
		.clk          (clk),
		.rst          (rst),
		.dec0_valid   (dec0_valid),
		.dec0_rt      (dec0_rt),
		.dec0_rs      (dec0_rs),
		.dec1_valid   (dec1_valid),
		.dec1_rt      (dec1_rt),
		.dec1_rs      (dec1_rs),
		.comp_valid   (comp_valid),
		.comp_tag     (comp_tag),
		.miss_valid   (miss_valid),
		.miss_tag     (miss_tag),
		.ready        (ready),
		.dec0_tag     (dec0_tag),
		.dec1_tag     (dec1_tag),
		.dec0_rs_src  (dec0_rs_src),
		.dec1_rs_src  (dec1_rs_src),
		.commit_valid (commit_valid),
		.commit_rt    (commit_rt),
		.commit_tag   (commit_tag)
	);

	bind rob_tracker rename_asserts u_asserts (
		.clk    (clk),
		.rst    (rst),
		.count  (count),
		.ready  (ready),
		.alloc0 (alloc0),
		.alloc1 (alloc1),
		.retire (retire),
		.flush  (flush)
	);

	always #10 clk = ~clk;

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic is_live(input rob_tag_t tag);
		logic found;
		found = 1'b0;
		foreach (order_q[i])
			if (order_q[i] == tag)
				found = 1'b1;
		return found;
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] want);
		check_count++;
		assert (got === want) else begin
			error_count++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic push_entry(input rob_tag_t tag, input reg_idx_t rt);
		order_q.push_back(tag);
		ent_rt[tag]   = rt;
		ent_done[tag] = 1'b0;
	endtask

	// One clock cycle where inputs go out after the edge and outputs are checked at the falling edge
	task automatic step_cycle(
		input logic     d0v,
		input reg_idx_t rt0,
		input reg_idx_t rs0,
		input logic     d1v,
		input reg_idx_t rt1,
		input reg_idx_t rs1,
		input logic     mv,
		input rob_tag_t mt,
		input logic     cv,
		input rob_tag_t ct,
		input src_t     e0,
		input src_t     e1
	);
		logic     exp_ready;
		logic     retiring;
		rob_tag_t tag_next1;
		@(posedge clk);
		#2;
		dec0_valid = d0v;
		dec0_rt    = rt0;
		dec0_rs    = rs0;
		dec1_valid = d1v;
		dec1_rt    = rt1;
		dec1_rs    = rs1;
		miss_valid = mv;
		miss_tag   = mt;
		comp_valid = cv;
		comp_tag   = ct;
		@(negedge clk);
		// Two free entries and no miss are needed to take a pair
		exp_ready = (order_q.size() <= (`ROB_ENTRIES - 2)) && !mv;
		tag_next1 = next_tag + 3'd1;
		expect_eq("ready", 32'(ready), 32'(exp_ready));
		expect_eq("dec0_tag", 32'(dec0_tag), 32'(next_tag));
		expect_eq("dec1_tag", 32'(dec1_tag), 32'(tag_next1));
		expect_eq("commit_valid", 32'(commit_valid), 32'(exp_commit));
		if (exp_commit) begin
			expect_eq("commit_tag", 32'(commit_tag), 32'(exp_ctag));
			expect_eq("commit_rt", 32'(commit_rt), 32'(exp_crt));
		end
		expect_eq("dec0_rs_src", 32'(dec0_rs_src), 32'(e0));
		expect_eq("dec1_rs_src", 32'(dec1_rs_src), 32'(e1));
		// Retirement looks at done bits from before this edge's completion
		retiring = 1'b0;
		if (order_q.size() > 0)
			retiring = ent_done[order_q[0]] && !mv;
		if (cv && is_live(ct))
			ent_done[ct] = 1'b1;
		exp_commit = retiring;
		if (retiring) begin
			exp_ctag = order_q[0];
			exp_crt  = ent_rt[order_q[0]];
			void'(order_q.pop_front());
		end
		if (mv) begin
			// Everything younger than the mispredicted entry is dropped
			while ((order_q.size() > 0) && (order_q[order_q.size() - 1] != mt))
				void'(order_q.pop_back());
			next_tag = mt + 3'd1;
		end else if (d0v && exp_ready) begin
			push_entry(next_tag, rt0);
			next_tag = next_tag + 3'd1;
			if (d1v) begin
				push_entry(next_tag, rt1);
				next_tag = next_tag + 3'd1;
			end
		end
	endtask

	// Completes random entries among the oldest ones until only keep entries are left
	// The kept entries stay not done, so later lookups do not depend on the random order
	task automatic drain_rob(input int keep);
		int       cycles;
		int       window;
		int       pick;
		logic     fire;
		rob_tag_t ctag;
		cycles = 0;
		while ((order_q.size() > keep) && !timed_out) begin
			rnd    = xorshift32(rnd);
			window = order_q.size() - keep;
			pick   = {16'd0, rnd[23:8]} % window;
			// About three cycles in four carry a completion
			fire   = rnd[0] | rnd[1];
			ctag   = order_q[pick];
			if (cycles >= DRAIN_LIMIT) begin
				timed_out = 1'b1;
				timeout_count++;
				$display("Timeout at %0t: the ROB still holds %0d entries after %0d cycles",
					$time, order_q.size(), cycles);
			end else begin
				step_cycle('0, '0, '0, '0, '0, '0, '0, '0, fire, ctag, SRC_NONE, SRC_NONE);
				cycles++;
			end
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin : main
		logic [59:0] vec;
		logic [3:0]  ctrl;
		int          line_idx;
		logic        stop;
		clk           = 1'b0;
		rst           = 1'b1;
		dec0_valid    = 1'b0;
		dec0_rt       = '0;
		dec0_rs       = '0;
		dec1_valid    = 1'b0;
		dec1_rt       = '0;
		dec1_rs       = '0;
		comp_valid    = 1'b0;
		comp_tag      = '0;
		miss_valid    = 1'b0;
		miss_tag      = '0;
		next_tag      = '0;
		exp_commit    = 1'b0;
		exp_ctag      = '0;
		exp_crt       = '0;
		rnd           = 32'h0e22ac02;
		timed_out     = 1'b0;
		check_count   = 0;
		error_count   = 0;
		timeout_count = 0;
		$readmemh("verif/rename_vectors.txt", vec_mem);

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		// A control digit of F is a plain cycle and 0 to 7 drains down to that many entries first
		line_idx = 0;
		stop     = 1'b0;
		while (!stop && !timed_out && (line_idx < VEC_DEPTH)) begin
			vec  = vec_mem[line_idx];
			ctrl = vec[59:56];
			if ($isunknown(ctrl) || (ctrl == 4'he)) begin
				stop = 1'b1;
			end else begin
				if (ctrl != 4'hf)
					drain_rob({28'd0, ctrl});
				if (!timed_out)
					step_cycle(vec[52], vec[48:44], vec[40:36], vec[32], vec[28:24],
						vec[20:16], vec[12], vec[10:8], 1'b0, '0, vec[7:4], vec[3:0]);
				line_idx++;
			end
		end
		assert (line_idx > 0) else begin
			error_count++;
			$display("No stimulus lines were read from the vector file");
		end

		// A completion on a miss edge still counts for an entry that survives the miss
		if (!timed_out && (order_q.size() > 0))
			step_cycle('0, '0, '0, '0, '0, '0, 1'b1, order_q[order_q.size() - 1], 1'b1,
				order_q[0], SRC_NONE, SRC_NONE);

		// Empty the ROB and catch the last commit pulse
		if (!timed_out)
			drain_rob(0);
		if (!timed_out)
			step_cycle('0, '0, '0, '0, '0, '0, '0, '0, '0, '0, SRC_NONE, SRC_NONE);

		$display("Checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count,
			timeout_count);
		if ((error_count == 0) && (timeout_count == 0))
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/rename_vectors.txt
// ctrl_d0v_rt0_rs0_d1v_rt1_rs1_miss_misstag_exp0_exp1, hex; ctrl F plain, 0-7 drain to N first, E ends
// Register fields take two digits, the expected sources are tags 0-7 or 8 for none
// After reset everything reads as none
f_0_00_00_0_00_00_0_0_8_8
f_0_00_05_0_00_07_0_0_8_8
// Youngest writer lookup and slot 1 bypass
f_1_05_01_1_06_05_0_0_8_0
f_1_07_05_1_05_06_0_0_0_1
f_1_00_05_1_09_00_0_0_3_8
f_1_0a_09_0_00_00_0_0_5_8
// Seven entries in use, offered pairs are refused
f_1_0b_0a_1_0c_0b_0_0_6_8
f_1_05_05_1_03_07_0_0_3_2
// Retire two, r5 keeps its newer writer and r6 clears
5_0_00_05_0_00_06_0_0_3_8
f_0_00_0b_0_00_0c_0_0_8_8
// Retire two more, r7 and r5 clear
3_0_00_07_0_00_05_0_0_8_8
f_1_09_0a_1_0a_09_0_0_6_7
// Miss on tag 6, the decode on the same edge is dropped
f_1_03_09_0_00_03_1_6_7_8
f_1_03_09_1_0b_0a_0_0_5_6
f_0_00_03_0_00_0b_0_0_7_0
// Miss on the oldest entry squashes every other one
f_0_00_09_0_00_03_1_4_5_7
f_1_01_09_1_02_01_0_0_8_5
f_0_00_03_0_00_0b_0_0_8_8
f_0_00_01_0_00_02_0_0_5_6
// Both slots write r4, slot 1 wins
f_1_04_02_1_04_04_0_0_6_7
f_0_00_04_0_00_00_0_0_0_8
// Miss on tag 7 brings r4 back to slot 0's writer
f_0_00_04_0_00_01_1_7_0_5
f_0_00_04_0_00_02_0_0_7_6
// Full drain, then a fresh pair wraps the tags
0_0_00_04_0_00_01_0_0_8_8
f_1_05_04_1_06_05_0_0_8_0
e_0_00_00_0_00_00_0_0_0_0
